// File: dsp_pkg.sv
// shared widths, channel counts, host register map and sequencer states
// for the shot controller; blocks pull these in with a wildcard import
package dsp_pkg;

	localparam int nproc = 4;
	localparam int nadc = 2;
	localparam int ndac = 4;

	localparam int adc_w = 64;
	localparam int dac_w = 256;
	localparam int acc_data_w = 64;
	localparam int shot_w = 32;

	localparam int wb_addr_w = 4;
	localparam int wb_data_w = 32;

	// sample pipeline depths up to the buffer write ports
	localparam int acq_delay = 4;
	localparam int mon_delay = 2;

	// word addresses, accumulation pointers follow reg_accaddr0 one per channel
	localparam logic [wb_addr_w-1:0] reg_ctrl = wb_addr_w'(0);
	localparam logic [wb_addr_w-1:0] reg_nshot = wb_addr_w'(1);
	localparam logic [wb_addr_w-1:0] reg_status = wb_addr_w'(2);
	localparam logic [wb_addr_w-1:0] reg_shotcnt = wb_addr_w'(3);
	localparam logic [wb_addr_w-1:0] reg_accaddr0 = wb_addr_w'(4);

	// control word strobes
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_resetacc_bit = 1;
	localparam int ctrl_recapture_bit = 2;

	typedef enum logic [2:0] {
		seq_idle,
		seq_start,
		seq_procrun,
		seq_moreshot,
		seq_shotadd,
		seq_done
	} seq_state_t;

endpackage

// File: dsp_host_regs.sv
// host register block on a Wishbone classic slave port
// control writes become one-cycle strobes, nshot is held for the sequencer,
// status, shot count and accumulation pointers are read back
`timescale 1ns/1ps

module dsp_host_regs import dsp_pkg::*; #(
	parameter int acc_addr_w = 11
) (
	input logic dspif,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_addr_w-1:0] wb_adr,
	input logic [wb_data_w-1:0] wb_dat_w,
	output logic wb_ack,
	output logic [wb_data_w-1:0] wb_dat_r,
	input logic run_done,
	input logic [shot_w-1:0] shot_count,
	input logic [acc_addr_w-1:0] acc_addr [nproc],
	output logic start,
	output logic resetacc,
	output logic recapture,
	output logic [shot_w-1:0] nshot
);

	logic access;
	logic wr_ctrl;
	logic done_flag;
	logic [wb_data_w-1:0] rd_word;

	// fresh cycle only, ack goes out on the next edge
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign wr_ctrl = access && wb_we && (wb_adr == reg_ctrl);

	always_ff @(posedge dspif) begin
		if (rst) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			resetacc <= 1'b0;
			recapture <= 1'b0;
			nshot <= '0;
		end else begin
			wb_ack <= access;
			start <= wr_ctrl && wb_dat_w[ctrl_start_bit];
			resetacc <= wr_ctrl && wb_dat_w[ctrl_resetacc_bit];
			recapture <= wr_ctrl && wb_dat_w[ctrl_recapture_bit];
			if (access && wb_we && (wb_adr == reg_nshot)) begin
				nshot <= shot_w'(wb_dat_w);
			end
		end
	end

	// sticky until the next run is started
	always_ff @(posedge dspif) begin
		if (rst) begin
			done_flag <= 1'b0;
		end else if (run_done) begin
			done_flag <= 1'b1;
		end else if (start) begin
			done_flag <= 1'b0;
		end
	end

	always_comb begin
		rd_word = '0;
		case (wb_adr)
			reg_nshot: rd_word = wb_data_w'(nshot);
			reg_status: rd_word[0] = done_flag;
			reg_shotcnt: rd_word = wb_data_w'(shot_count);
			default: rd_word = '0;
		endcase
		for (int i = 0; i < nproc; i++) begin
			if (wb_adr == wb_addr_w'(reg_accaddr0 + i)) begin
				rd_word = wb_data_w'(acc_addr[i]);
			end
		end
	end

	// read word is presented together with ack
	always_ff @(posedge dspif) begin
		if (access) begin
			wb_dat_r <= rd_word;
		end
	end

	a_ack_single: assert property (@(posedge dspif) disable iff (rst)
		wb_ack |=> !wb_ack);

endmodule

// File: shot_sequencer.sv
// shot sequencer for the processor cores
// a start strobe latches nshot, then each shot releases the core reset,
// waits for every core to report done and counts the shot
// run_done pulses once after the last shot
`timescale 1ns/1ps

module shot_sequencer import dsp_pkg::*; (
	input logic dspif,
	input logic rst,
	input logic start,
	input logic [shot_w-1:0] nshot,
	input logic [nproc-1:0] proc_done,
	output logic [nproc-1:0] proc_reset,
	output logic run_done,
	output logic [shot_w-1:0] shot_count
);

	seq_state_t state;
	seq_state_t state_nxt;
	logic [shot_w-1:0] nshot_q;
	logic launch;
	logic all_done;
	logic last_shot;

	assign launch = (state == seq_idle) && start;
	assign all_done = &proc_done;
	// zero shots still means one pass through the cores
	assign last_shot = (nshot_q == '0) || (shot_count >= nshot_q);

	always_ff @(posedge dspif) begin
		if (rst) begin
			state <= seq_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			seq_idle: begin
				if (start) begin
					state_nxt = seq_start;
				end
			end
			seq_start: state_nxt = seq_procrun;
			seq_procrun: begin
				if (all_done) begin
					state_nxt = seq_moreshot;
				end
			end
			seq_moreshot: state_nxt = last_shot ? seq_done : seq_shotadd;
			// spacer, keeps the cores in reset between shots
			seq_shotadd: state_nxt = seq_start;
			seq_done: state_nxt = seq_idle;
			default: state_nxt = seq_idle;
		endcase
	end

	// outputs registered off the next state
	always_ff @(posedge dspif) begin
		if (rst) begin
			proc_reset <= '1;
			run_done <= 1'b0;
			shot_count <= '0;
		end else begin
			proc_reset <= {nproc{state_nxt != seq_procrun}};
			run_done <= (state_nxt == seq_done);
			if (launch) begin
				shot_count <= '0;
			end else if ((state == seq_procrun) && all_done) begin
				shot_count <= shot_count + 1'b1;
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (launch) begin
			nshot_q <= nshot;
		end
	end

	a_idle_reset: assert property (@(posedge dspif) disable iff (rst)
		(state == seq_idle) |-> &proc_reset);

endmodule

// File: capture_writer.sv
// delayed sample capture into an on-chip buffer
// samples run through a register chain, the write address restarts at 0
// on recapture and stops at all ones, so one recapture fills the buffer once
`timescale 1ns/1ps

module capture_writer #(
	parameter int width = 64,
	parameter int addr_w = 13,
	parameter int delay = 4
) (
	input logic dspif,
	input logic rst,
	input logic recapture,
	input logic [width-1:0] sample,
	output logic [width-1:0] data,
	output logic [addr_w-1:0] addr,
	output logic we
);

	// last address that is still written
	localparam logic [addr_w-1:0] addr_final = ~addr_w'(1);

	logic [width-1:0] pipe [delay];
	logic locked;

	assign locked = &addr;

	always_ff @(posedge dspif) begin
		pipe[0] <= sample;
		for (int i = 1; i < delay; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	assign data = pipe[delay-1];

	always_ff @(posedge dspif) begin
		if (rst || recapture) begin
			addr <= '0;
		end else if (!locked) begin
			addr <= addr + 1'b1;
		end
	end

	// armed by recapture only, drops as the address locks
	always_ff @(posedge dspif) begin
		if (rst) begin
			we <= 1'b0;
		end else if (recapture) begin
			we <= 1'b1;
		end else if (addr == addr_final) begin
			we <= 1'b0;
		end
	end

	a_no_write_locked: assert property (@(posedge dspif) disable iff (rst)
		locked |-> !we);

endmodule

// File: acc_pointer.sv
// accumulation buffer write side for every processor channel
// a valid strobe gives a write one cycle later with the data it sampled,
// the pointer counts writes since resetacc and saturates at all ones
`timescale 1ns/1ps

module acc_pointer import dsp_pkg::*; #(
	parameter int addr_w = 11
) (
	input logic dspif,
	input logic rst,
	input logic resetacc,
	input logic [nproc-1:0] acc_valid,
	input logic [acc_data_w-1:0] acc_in [nproc],
	output logic [acc_data_w-1:0] acc_data [nproc],
	output logic [addr_w-1:0] acc_addr [nproc],
	output logic [nproc-1:0] acc_we
);

	always_ff @(posedge dspif) begin
		for (int i = 0; i < nproc; i++) begin
			if (acc_valid[i]) begin
				acc_data[i] <= acc_in[i];
			end
		end
	end

	// pointer moves after each write, stays put once full
	always_ff @(posedge dspif) begin
		if (rst) begin
			acc_we <= '0;
			for (int i = 0; i < nproc; i++) begin
				acc_addr[i] <= '0;
			end
		end else begin
			acc_we <= acc_valid;
			for (int i = 0; i < nproc; i++) begin
				if (resetacc) begin
					acc_addr[i] <= '0;
				end else if (acc_we[i] && !(&acc_addr[i])) begin
					acc_addr[i] <= acc_addr[i] + 1'b1;
				end
			end
		end
	end

endmodule

// File: dsp_top.sv
// top level of the shot controller block
// joins the host register port, the shot sequencer, the ADC and DAC
// monitor capture writers and the accumulation pointers
`timescale 1ns/1ps

module dsp_top import dsp_pkg::*; #(
	parameter int acq_addr_w = 13,
	parameter int mon_addr_w = 9,
	parameter int acc_addr_w = 11
) (
	input logic dspif,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_addr_w-1:0] wb_adr,
	input logic [wb_data_w-1:0] wb_dat_w,
	output logic wb_ack,
	output logic [wb_data_w-1:0] wb_dat_r,
	input logic [nproc-1:0] proc_done,
	input logic [adc_w-1:0] adc [nadc],
	input logic [dac_w-1:0] dac [ndac],
	input logic [nproc-1:0] acc_valid,
	input logic [acc_data_w-1:0] acc_in [nproc],
	output logic [nproc-1:0] proc_reset,
	output logic [adc_w-1:0] acq_data [nadc],
	output logic [acq_addr_w-1:0] acq_addr [nadc],
	output logic [nadc-1:0] acq_we,
	output logic [dac_w-1:0] mon_data [ndac],
	output logic [mon_addr_w-1:0] mon_addr [ndac],
	output logic [ndac-1:0] mon_we,
	output logic [acc_data_w-1:0] acc_data [nproc],
	output logic [acc_addr_w-1:0] acc_addr [nproc],
	output logic [nproc-1:0] acc_we
);

	logic start;
	logic resetacc;
	logic recapture;
	logic run_done;
	logic [shot_w-1:0] nshot;
	logic [shot_w-1:0] shot_count;

	dsp_host_regs #(.acc_addr_w(acc_addr_w)) u_regs (
		.dspif(dspif),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.run_done(run_done),
		.shot_count(shot_count),
		.acc_addr(acc_addr),
		.start(start),
		.resetacc(resetacc),
		.recapture(recapture),
		.nshot(nshot)
	);

	shot_sequencer u_seq (
		.dspif(dspif),
		.rst(rst),
		.start(start),
		.nshot(nshot),
		.proc_done(proc_done),
		.proc_reset(proc_reset),
		.run_done(run_done),
		.shot_count(shot_count)
	);

	for (genvar i = 0; i < nadc; i++) begin : g_acq
		capture_writer #(.width(adc_w), .addr_w(acq_addr_w), .delay(acq_delay)) u_acq (
			.dspif(dspif),
			.rst(rst),
			.recapture(recapture),
			.sample(adc[i]),
			.data(acq_data[i]),
			.addr(acq_addr[i]),
			.we(acq_we[i])
		);
	end

	for (genvar i = 0; i < ndac; i++) begin : g_mon
		capture_writer #(.width(dac_w), .addr_w(mon_addr_w), .delay(mon_delay)) u_mon (
			.dspif(dspif),
			.rst(rst),
			.recapture(recapture),
			.sample(dac[i]),
			.data(mon_data[i]),
			.addr(mon_addr[i]),
			.we(mon_we[i])
		);
	end

	acc_pointer #(.addr_w(acc_addr_w)) u_acc (
		.dspif(dspif),
		.rst(rst),
		.resetacc(resetacc),
		.acc_valid(acc_valid),
		.acc_in(acc_in),
		.acc_data(acc_data),
		.acc_addr(acc_addr),
		.acc_we(acc_we)
	);

endmodule

// File: tb_dsp.sv
// self-checking testbench for the shot controller top level
// each line of tb_input.txt names an operation: reset, nshot, run, capture or acc
// a negedge monitor checks every buffer write against the driven samples
`timescale 1ns/1ps

module tb_dsp import dsp_pkg::*; ();

	localparam int acq_aw = 4;
	localparam int mon_aw = 3;
	localparam int acc_aw = 3;
	localparam int acq_words = (1 << acq_aw) - 1;
	localparam int mon_words = (1 << mon_aw) - 1;
	localparam int acc_top = (1 << acc_aw) - 1;

	logic dspif = 1'b0;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [wb_addr_w-1:0] wb_adr;
	logic [wb_data_w-1:0] wb_dat_w;
	logic wb_ack;
	logic [wb_data_w-1:0] wb_dat_r;
	logic [nproc-1:0] proc_done;
	logic [adc_w-1:0] adc [nadc];
	logic [dac_w-1:0] dac [ndac];
	logic [nproc-1:0] acc_valid;
	logic [acc_data_w-1:0] acc_in [nproc];
	logic [nproc-1:0] proc_reset;
	logic [adc_w-1:0] acq_data [nadc];
	logic [acq_aw-1:0] acq_addr [nadc];
	logic [nadc-1:0] acq_we;
	logic [dac_w-1:0] mon_data [ndac];
	logic [mon_aw-1:0] mon_addr [ndac];
	logic [ndac-1:0] mon_we;
	logic [acc_data_w-1:0] acc_data [nproc];
	logic [acc_aw-1:0] acc_addr [nproc];
	logic [nproc-1:0] acc_we;

	string ops [$];
	int arg_nshot [$];
	int arg_lat [$];
	int arg_cnt [$];
	int nrec = 0;
	int core_lat = 1;
	int lat_cnt;
	int clr_req = 0;
	logic [63:0] rng;

	// monitor state, cleared whenever clr_req moves
	int clr_seen = 0;
	int acq_cnt [nadc];
	int mon_cnt [ndac];
	int acc_cnt [nproc];
	int shot_pulses = 0;
	logic preset_prev = 1'b1;
	logic [nproc-1:0] valid_prev = '0;
	logic [acc_data_w-1:0] acc_in_prev [nproc];
	logic [adc_w-1:0] adc_hist [nadc][acq_delay];
	logic [dac_w-1:0] dac_hist [ndac][mon_delay];

	dsp_top #(.acq_addr_w(acq_aw), .mon_addr_w(mon_aw), .acc_addr_w(acc_aw)) u_dut (.*);

	always #50 dspif = ~dspif;

	function automatic logic [63:0] xorshift(input logic [63:0] s);
		s ^= s << 13;
		s ^= s >> 7;
		s ^= s << 17;
		return s;
	endfunction

	function automatic int sat(input int n, input int top);
		return (n > top) ? top : n;
	endfunction

	task automatic stop_failed();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	task automatic wb_access(input logic we, input logic [wb_addr_w-1:0] adr,
			input logic [wb_data_w-1:0] wdata, output logic [wb_data_w-1:0] rdata);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do begin
			@(posedge dspif);
			#1;
		end while (wb_ack !== 1'b1);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		// one ack per access
		@(posedge dspif);
		#1;
		check_value("wb_ack", 256'(wb_ack), 256'(0));
	endtask

	task automatic wb_write(input logic [wb_addr_w-1:0] adr, input logic [wb_data_w-1:0] d);
		logic [wb_data_w-1:0] unused;
		wb_access(1'b1, adr, d, unused);
	endtask

	task automatic wb_read(input logic [wb_addr_w-1:0] adr, output logic [wb_data_w-1:0] d);
		wb_access(1'b0, adr, '0, d);
	endtask

	task automatic apply_reset();
		clr_req++;
		rst = 1'b1;
		repeat (5) @(posedge dspif);
		#1;
		rst = 1'b0;
	endtask

	task automatic check_idle_state();
		logic [wb_data_w-1:0] d;
		check_value("proc_reset", 256'(proc_reset), 256'({nproc{1'b1}}));
		check_value("acq_we", 256'(acq_we), 256'(0));
		check_value("mon_we", 256'(mon_we), 256'(0));
		check_value("acc_we", 256'(acc_we), 256'(0));
		check_value("wb_ack", 256'(wb_ack), 256'(0));
		wb_read(reg_status, d);
		check_value("status.done", 256'(d[0]), 256'(0));
	endtask

	task automatic nshot_rw(input int v);
		logic [wb_data_w-1:0] d;
		wb_write(reg_nshot, wb_data_w'(v));
		wb_read(reg_nshot, d);
		check_value("nshot", 256'(d), 256'(wb_data_w'(v)));
	endtask

	task automatic run_shots(input int n, input int lat);
		logic [wb_data_w-1:0] d;
		int exp_shots;
		exp_shots = (n == 0) ? 1 : n;
		core_lat = (lat < 1) ? 1 : lat;
		clr_req++;
		wb_write(reg_nshot, wb_data_w'(n));
		wb_write(reg_ctrl, wb_data_w'(1) << ctrl_start_bit);
		d = '0;
		while (d[0] !== 1'b1) begin
			wb_read(reg_status, d);
		end
		check_value("proc_reset low periods", 256'(shot_pulses), 256'(exp_shots));
		wb_read(reg_shotcnt, d);
		check_value("shot_count", 256'(d), 256'(exp_shots));
		check_value("proc_reset", 256'(proc_reset), 256'({nproc{1'b1}}));
	endtask

	function automatic bit capture_complete();
		bit ok = 1'b1;
		for (int i = 0; i < nadc; i++) begin
			if (acq_cnt[i] < acq_words) ok = 1'b0;
		end
		for (int i = 0; i < ndac; i++) begin
			if (mon_cnt[i] < mon_words) ok = 1'b0;
		end
		return ok;
	endfunction

	task automatic capture_run();
		clr_req++;
		wb_write(reg_ctrl, wb_data_w'(1) << ctrl_recapture_bit);
		while (!capture_complete()) begin
			@(posedge dspif);
			#1;
		end
		// buffers are full, no further writes may follow
		repeat (4) @(posedge dspif);
		#1;
		for (int i = 0; i < nadc; i++) begin
			check_value("acq write count", 256'(acq_cnt[i]), 256'(acq_words));
		end
		for (int i = 0; i < ndac; i++) begin
			check_value("mon write count", 256'(mon_cnt[i]), 256'(mon_words));
		end
		check_value("acq_we", 256'(acq_we), 256'(0));
		check_value("mon_we", 256'(mon_we), 256'(0));
	endtask

	task automatic acc_run(input int k);
		logic [wb_data_w-1:0] d;
		bit waiting;
		clr_req++;
		wb_write(reg_ctrl, wb_data_w'(1) << ctrl_resetacc_bit);
		repeat (k) begin
			acc_valid = '1;
			@(posedge dspif);
			#1;
		end
		acc_valid = '0;
		do begin
			@(posedge dspif);
			#1;
			waiting = 1'b0;
			for (int i = 0; i < nproc; i++) begin
				if (acc_cnt[i] < k) waiting = 1'b1;
			end
		end while (waiting);
		for (int i = 0; i < nproc; i++) begin
			check_value("acc write count", 256'(acc_cnt[i]), 256'(k));
			wb_read(wb_addr_w'(reg_accaddr0 + i), d);
			check_value("acc pointer", 256'(d), 256'(sat(k, acc_top)));
		end
	endtask

	// sample sources, new values every cycle
	initial begin
		rng = 64'd55511;
		for (int i = 0; i < nadc; i++) adc[i] = '0;
		for (int i = 0; i < ndac; i++) dac[i] = '0;
		for (int i = 0; i < nproc; i++) acc_in[i] = '0;
		forever begin
			@(posedge dspif);
			#1;
			for (int i = 0; i < nadc; i++) begin
				rng = xorshift(rng);
				adc[i] = rng;
			end
			for (int i = 0; i < ndac; i++) begin
				for (int j = 0; j < dac_w / 64; j++) begin
					rng = xorshift(rng);
					dac[i][j*64 +: 64] = rng;
				end
			end
			for (int i = 0; i < nproc; i++) begin
				rng = xorshift(rng);
				acc_in[i] = rng;
			end
		end
	end

	// processor cores report done core_lat cycles into the shot
	initial begin
		proc_done = '0;
		lat_cnt = 0;
		forever begin
			@(posedge dspif);
			#1;
			if (proc_reset[0]) begin
				lat_cnt = 0;
				proc_done = '0;
			end else begin
				lat_cnt++;
				if (lat_cnt >= core_lat) proc_done = '1;
			end
		end
	end

	always @(negedge dspif) begin
		if (clr_seen != clr_req) begin
			clr_seen = clr_req;
			shot_pulses = 0;
			for (int i = 0; i < nadc; i++) acq_cnt[i] = 0;
			for (int i = 0; i < ndac; i++) mon_cnt[i] = 0;
			for (int i = 0; i < nproc; i++) acc_cnt[i] = 0;
		end
		if (!rst) begin
			if (preset_prev && !proc_reset[0]) shot_pulses++;
			for (int i = 0; i < nadc; i++) begin
				if (acq_we[i]) begin
					check_value("acq_addr", 256'(acq_addr[i]), 256'(acq_cnt[i]));
					check_value("acq_data", 256'(acq_data[i]), 256'(adc_hist[i][acq_delay-1]));
					acq_cnt[i]++;
				end
			end
			for (int i = 0; i < ndac; i++) begin
				if (mon_we[i]) begin
					check_value("mon_addr", 256'(mon_addr[i]), 256'(mon_cnt[i]));
					check_value("mon_data", mon_data[i], dac_hist[i][mon_delay-1]);
					mon_cnt[i]++;
				end
			end
			for (int i = 0; i < nproc; i++) begin
				check_value("acc_we", 256'(acc_we[i]), 256'(valid_prev[i]));
				if (acc_we[i]) begin
					check_value("acc_addr", 256'(acc_addr[i]), 256'(sat(acc_cnt[i], acc_top)));
					check_value("acc_data", 256'(acc_data[i]), 256'(acc_in_prev[i]));
					acc_cnt[i]++;
				end
			end
		end
		for (int i = 0; i < nadc; i++) begin
			for (int j = acq_delay - 1; j > 0; j--) adc_hist[i][j] = adc_hist[i][j-1];
			adc_hist[i][0] = adc[i];
		end
		for (int i = 0; i < ndac; i++) begin
			for (int j = mon_delay - 1; j > 0; j--) dac_hist[i][j] = dac_hist[i][j-1];
			dac_hist[i][0] = dac[i];
		end
		for (int i = 0; i < nproc; i++) acc_in_prev[i] = acc_in[i];
		valid_prev = acc_valid;
		preset_prev = proc_reset[0];
	end

	initial begin
		wait (nrec > 0);
		repeat (nrec * 2000) @(posedge dspif);
		$display("timeout: the records did not finish within %0d clock cycles", nrec * 2000);
		stop_failed();
	end

	initial begin
		int fd;
		int n;
		int a;
		int b;
		int c;
		string line;
		string op;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		acc_valid = '0;
		fd = $fopen("tb_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb_input.txt");
			stop_failed();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line[0] == "#") continue;
			n = $sscanf(line, "%s %d %d %d", op, a, b, c);
			if (n == 4) begin
				ops.push_back(op);
				arg_nshot.push_back(a);
				arg_lat.push_back(b);
				arg_cnt.push_back(c);
			end
		end
		$fclose(fd);
		nrec = ops.size();
		if (nrec == 0) begin
			$display("tb_input.txt holds no test records");
			stop_failed();
		end
		apply_reset();
		for (int r = 0; r < nrec; r++) begin
			if (ops[r] == "reset") begin
				apply_reset();
				check_idle_state();
			end else if (ops[r] == "nshot") begin
				nshot_rw(arg_nshot[r]);
			end else if (ops[r] == "run") begin
				run_shots(arg_nshot[r], arg_lat[r]);
			end else if (ops[r] == "capture") begin
				capture_run();
			end else if (ops[r] == "acc") begin
				acc_run(arg_cnt[r]);
			end else begin
				$display("unknown operation %s in tb_input.txt", ops[r]);
				stop_failed();
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: tb_input.txt
# columns: operation nshot core_latency count
# operation is reset, nshot, run, capture or acc; unused columns hold 0 or 1
reset 0 1 0
nshot 1234 1 0
nshot 305419896 1 0
run 0 3 0
run 1 5 0
run 5 2 0
capture 0 1 0
acc 0 1 3
acc 0 1 7
acc 0 1 10
capture 0 1 0
run 5 1 0
reset 0 1 0
run 2 8 0
acc 0 1 1
capture 0 1 0
nshot 0 1 0

// File: sim.f
dsp_pkg.sv
dsp_host_regs.sv
shot_sequencer.sv
capture_writer.sv
acc_pointer.sv
dsp_top.sv
tb_dsp.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --timing --assert
TOP ?= tb_dsp
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG = TEST RESULT: FAIL
PASS_MSG = TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: build
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
